//--- include/fpu_mul_defs.svh
// width macros for the multiply fraction datapath
`ifndef FPU_MUL_DEFS_SVH
`define FPU_MUL_DEFS_SVH

// queued operand word, double or single fraction inside
`define FPU_MUL_IN_W 55

// array operand incl hidden bit
`define FPU_MUL_FRAC_W 53

`define FPU_MUL_OUT_W 52	// result fraction
`define FPU_MUL_PROD_W 106	// full array product

// stage-5 fraction, 54 result bits and a sticky
`define FPU_MUL_M5_W 55

`define FPU_MUL_SHCNT_W 6	// post-norm shift amount
`define FPU_MUL_LD0_W 6	// leading-zero count

// single fraction sits in the top of the operand word
`define FPU_MUL_SNG_LSB 32

`endif

//--- hdl/fpu_mul_fmt_pkg.sv
// operand, fraction, product and stage-5 flag types
`include "fpu_mul_defs.svh"

package fpu_mul_fmt_pkg;

	// queued operand, dbl frac in 51:0, sng frac in 54:32
	typedef logic [`FPU_MUL_IN_W-1:0] opnd_t;

	// array operand incl hidden bit
	typedef logic [`FPU_MUL_FRAC_W-1:0] frac_t;

	typedef logic [`FPU_MUL_PROD_W-1:0] prod_t;	// array product

	// stage-5 fraction, sticky in bit 0
	typedef logic [`FPU_MUL_M5_W-1:0] m5frac_t;

	typedef logic [`FPU_MUL_OUT_W-1:0] res_t;	// rounded result fraction

	// stage-5 status toward exponent and flag logic
	typedef struct packed {
		logic dbl_nx;	// bits lost below double lsb
		logic sng_nx;	// bits lost below single lsb
		logic neq_0;	// any bit set at all
		logic cout;	// carry out of rounding add
	} m5flags_t;

endpackage

//--- hdl/fpu_mul_ctl_pkg.sv
// operation class and select-line structs for the multiply control
package fpu_mul_ctl_pkg;

	// operand class from the exponent side
	typedef enum logic [1:0] {
		CLS_NORM = 2'd0,
		CLS_DNRM = 2'd1,
		CLS_INF  = 2'd2,
		CLS_ZERO = 2'd3
	} opnd_class_t;

	// stage-1 request, queued with the operands
	typedef struct packed {
		logic        dblop;	// double precision op
		opnd_class_t class1;
		opnd_class_t class2;
		logic        snan1;	// signalling nan, gets quieted
		logic        snan2;
		logic        inf_zero;	// inf times zero, invalid pattern
	} m1_op_t;

	// one-hot injection select for one operand
	typedef struct packed {
		logic dbl_norm;
		logic dbl_dnrm;
		logic sng_norm;
		logic sng_dnrm;
		logic inf;
	} inj_sel_t;

	typedef struct packed {
		inj_sel_t sel1;
		inj_sel_t sel2;
		logic     dblop;	// lead0 alignment
		logic     snan1;
		logic     snan2;
		logic     inf_zero_dbl;	// fills low 29 bits of op2 pattern
		logic     inf_zero_sng;	// fills upper 23 bits
	} m1_sel_t;

	// stage-5 request
	typedef struct packed {
		logic fmuls;	// single mul
		logic fmulda;	// double mul
		logic round_up;
		logic in_of;	// overflow
		logic to_0;	// overflow goes to max finite
	} m5_op_t;

	typedef struct packed {
		logic sel_add;	// rounded fraction
		logic sel_frac;	// unrounded
		logic sel_max;	// all ones
		logic inc_sng;	// increment at bit 29
		logic inc_dbl;	// increment at bit 0
	} m5_sel_t;

endpackage

//--- hdl/fpu_mul_lead0.sv
// 53-bit leading-zero counter, halving tree
`include "fpu_mul_defs.svh"

module fpu_mul_lead0 (
	input  fpu_mul_fmt_pkg::frac_t    i_din,
	output logic [`FPU_MUL_LD0_W-1:0] o_lead0
);

	logic [63:0] v0;	// padded to a power of two
	logic [31:0] v1;
	logic [15:0] v2;
	logic [7:0]  v3;
	logic [3:0]  v4;
	logic [1:0]  v5;

	// ones in the pad so an all-zero input stops at 53
	assign v0 = {i_din, {(64-`FPU_MUL_FRAC_W){1'b1}}};

	// each level picks the upper half unless it is empty
	assign o_lead0[5] = ~|v0[63:32];
	assign v1         = o_lead0[5] ? v0[31:0] : v0[63:32];

	assign o_lead0[4] = ~|v1[31:16];
	assign v2         = o_lead0[4] ? v1[15:0] : v1[31:16];

	assign o_lead0[3] = ~|v2[15:8];
	assign v3         = o_lead0[3] ? v2[7:0] : v2[15:8];

	assign o_lead0[2] = ~|v3[7:4];
	assign v4         = o_lead0[2] ? v3[3:0] : v3[7:4];

	assign o_lead0[1] = ~|v4[3:2];
	assign v5         = o_lead0[1] ? v4[1:0] : v4[3:2];

	assign o_lead0[0] = ~v5[1];	// last pair

endmodule

//--- hdl/fpu_mul_ctl.sv
// multiply fraction control, stage-1 class decode and stage-5 output select
module fpu_mul_ctl (
	input  logic                     i_rclk,
	input  logic                     i_reset,
	input  logic                     i_step,	// pipe advance
	input  fpu_mul_ctl_pkg::m1_op_t  i_m1_op,
	input  fpu_mul_ctl_pkg::m5_op_t  i_m5_op,
	output fpu_mul_ctl_pkg::m1_sel_t o_m1_sel,
	output fpu_mul_ctl_pkg::m5_sel_t o_m5_sel
);

	fpu_mul_ctl_pkg::m1_op_t m1_op_q;	// op class, moves with operand regs

	// class plus format to one-hot select, zero selects nothing
	function automatic fpu_mul_ctl_pkg::inj_sel_t dec_class(
		input logic                         dblop,
		input fpu_mul_ctl_pkg::opnd_class_t cls
	);
		fpu_mul_ctl_pkg::inj_sel_t s;
		s          = '0;
		s.dbl_norm = dblop & (cls == fpu_mul_ctl_pkg::CLS_NORM);
		s.dbl_dnrm = dblop & (cls == fpu_mul_ctl_pkg::CLS_DNRM);
		s.sng_norm = ~dblop & (cls == fpu_mul_ctl_pkg::CLS_NORM);
		s.sng_dnrm = ~dblop & (cls == fpu_mul_ctl_pkg::CLS_DNRM);
		s.inf      = (cls == fpu_mul_ctl_pkg::CLS_INF);	// either format
		return s;
	endfunction

	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			m1_op_q <= '0;
		end else if (i_step) begin
			m1_op_q <= i_m1_op;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 1 selects
	////////////////////////////////////////////////////////////////////////////

	assign o_m1_sel.sel1         = dec_class(m1_op_q.dblop, m1_op_q.class1);
	assign o_m1_sel.sel2         = dec_class(m1_op_q.dblop, m1_op_q.class2);
	assign o_m1_sel.dblop        = m1_op_q.dblop;
	assign o_m1_sel.snan1        = m1_op_q.snan1;
	assign o_m1_sel.snan2        = m1_op_q.snan2;
	assign o_m1_sel.inf_zero_sng = m1_op_q.inf_zero;	// 23 bits in both formats
	assign o_m1_sel.inf_zero_dbl = m1_op_q.inf_zero & m1_op_q.dblop;

	////////////////////////////////////////////////////////////////////////////
	// stage 5 selects
	////////////////////////////////////////////////////////////////////////////

	// overflow wins, without to_0 the fraction goes to zero (infinity)
	assign o_m5_sel.sel_add  = i_m5_op.round_up & ~i_m5_op.in_of;
	assign o_m5_sel.sel_frac = ~i_m5_op.round_up & ~i_m5_op.in_of;
	assign o_m5_sel.sel_max  = i_m5_op.in_of & i_m5_op.to_0;
	assign o_m5_sel.inc_sng  = i_m5_op.fmuls;
	assign o_m5_sel.inc_dbl  = i_m5_op.fmulda & ~i_m5_op.fmuls;	// one position only

endmodule

//--- hdl/fpu_mul_frac_in.sv
// operand registers, stage-1 fraction injection and leading-zero inputs
`include "fpu_mul_defs.svh"

module fpu_mul_frac_in (
	input  logic                      i_rclk,
	input  logic                      i_reset,
	input  logic                      i_step,
	input  fpu_mul_fmt_pkg::opnd_t    i_in1,
	input  fpu_mul_fmt_pkg::opnd_t    i_in2,
	input  fpu_mul_ctl_pkg::m1_sel_t  i_m1_sel,
	output fpu_mul_fmt_pkg::frac_t    o_frac1_array,	// inverted for the array
	output fpu_mul_fmt_pkg::frac_t    o_frac2_array,
	output logic [`FPU_MUL_LD0_W-1:0] o_ld0_1,
	output logic [`FPU_MUL_LD0_W-1:0] o_ld0_2
);

	fpu_mul_fmt_pkg::opnd_t in1_q;
	fpu_mul_fmt_pkg::opnd_t in2_q;
	fpu_mul_fmt_pkg::frac_t frac1;
	fpu_mul_fmt_pkg::frac_t frac2;
	fpu_mul_fmt_pkg::frac_t inf_pat2;	// op2 inf pattern, op1 is hidden bit only

	// AND-OR mux of the injected forms, selects are one-hot
	function automatic fpu_mul_fmt_pkg::frac_t inject(
		input fpu_mul_fmt_pkg::opnd_t    opnd,
		input fpu_mul_ctl_pkg::inj_sel_t sel,
		input logic                      snan,
		input fpu_mul_fmt_pkg::frac_t    inf_pat
	);
		fpu_mul_fmt_pkg::frac_t f;
		f = ({`FPU_MUL_FRAC_W{sel.dbl_norm}} & {1'b1, opnd[51] | snan, opnd[50:0]})
			| ({`FPU_MUL_FRAC_W{sel.dbl_dnrm}} & {opnd[51:0], 1'b0})	// one place up
			| ({`FPU_MUL_FRAC_W{sel.sng_norm}}
				& {1'b1, opnd[`FPU_MUL_IN_W-1] | snan,
				opnd[`FPU_MUL_IN_W-2:`FPU_MUL_SNG_LSB], 29'b0})
			| ({`FPU_MUL_FRAC_W{sel.sng_dnrm}}
				& {opnd[`FPU_MUL_IN_W-1:`FPU_MUL_SNG_LSB], 30'b0})
			| ({`FPU_MUL_FRAC_W{sel.inf}} & inf_pat);
		return f;
	endfunction

	// msb-aligned fraction for the zero count
	function automatic fpu_mul_fmt_pkg::frac_t align(
		input fpu_mul_fmt_pkg::opnd_t opnd,
		input logic                   dblop
	);
		fpu_mul_fmt_pkg::frac_t f;
		f = dblop ? {opnd[51:0], 1'b0} : {opnd[`FPU_MUL_IN_W-1:`FPU_MUL_SNG_LSB], 30'b0};
		return f;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// input stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			in1_q <= '0;
			in2_q <= '0;
		end else if (i_step) begin
			in1_q <= i_in1;
			in2_q <= i_in2;
		end
	end

	assign inf_pat2 = {1'b1, {23{i_m1_sel.inf_zero_sng}}, {29{i_m1_sel.inf_zero_dbl}}};

	assign frac1 = inject(in1_q, i_m1_sel.sel1, i_m1_sel.snan1,
		{1'b1, {(`FPU_MUL_FRAC_W-1){1'b0}}});
	assign frac2 = inject(in2_q, i_m1_sel.sel2, i_m1_sel.snan2, inf_pat2);

	assign o_frac1_array = ~frac1;
	assign o_frac2_array = frac2;

	fpu_mul_lead0 u_ld0_1 (
		.i_din   (align(in1_q, i_m1_sel.dblop)),
		.o_lead0 (o_ld0_1)
	);

	fpu_mul_lead0 u_ld0_2 (
		.i_din   (align(in2_q, i_m1_sel.dblop)),
		.o_lead0 (o_ld0_2)
	);

endmodule

//--- hdl/fpu_mul_frac_norm.sv
// post-normalization shift count register, left and right shifters, stage-5 fraction
`include "fpu_mul_defs.svh"

module fpu_mul_frac_norm (
	input  logic                        i_rclk,
	input  logic                        i_reset,
	input  logic                        i_step,
	input  fpu_mul_fmt_pkg::prod_t      i_m4_frac,	// array product
	input  logic [`FPU_MUL_SHCNT_W-1:0] i_m4_sh_cnt,
	input  logic [`FPU_MUL_LD0_W:0]     i_m3b_ld0_inv,	// summed operand zeros
	input  logic                        i_left,
	input  logic                        i_right,
	output logic [`FPU_MUL_LD0_W:0]     o_m3_ld0_inv,
	output logic [1:0]                  o_m4_shl_hi,	// left shift bits 55:54
	output fpu_mul_fmt_pkg::m5frac_t    o_m5_frac
);

	localparam int SHR_W = `FPU_MUL_PROD_W + 63;	// product plus room to shift out

	logic [`FPU_MUL_SHCNT_W-1:0] sh_cnt_q;
	logic [`FPU_MUL_LD0_W:0]     ld0_inv_q;
	fpu_mul_fmt_pkg::prod_t      shl_full;
	logic [SHR_W-1:0]            shr_full;
	logic [`FPU_MUL_M5_W:0]      shl;	// 55 kept bits and sticky
	logic [`FPU_MUL_M5_W:0]      shr;
	fpu_mul_fmt_pkg::m5frac_t    m5_in;
	fpu_mul_fmt_pkg::m5frac_t    m5_q;

	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			sh_cnt_q  <= '0;
			ld0_inv_q <= '0;
		end else if (i_step) begin
			sh_cnt_q  <= i_m4_sh_cnt;
			ld0_inv_q <= i_m3b_ld0_inv;
		end
	end

	assign o_m3_ld0_inv = ld0_inv_q;

	////////////////////////////////////////////////////////////////////////////
	// shifters
	////////////////////////////////////////////////////////////////////////////

	// left, for products that came out short
	assign shl_full = i_m4_frac << sh_cnt_q;
	assign shl = {shl_full[`FPU_MUL_PROD_W-1 -: `FPU_MUL_M5_W],
		|shl_full[`FPU_MUL_PROD_W-`FPU_MUL_M5_W-1:0]};

	// right, denormal result
	assign shr_full = {i_m4_frac, 63'b0} >> sh_cnt_q;
	assign shr = {shr_full[SHR_W-1 -: `FPU_MUL_M5_W],
		|shr_full[SHR_W-`FPU_MUL_M5_W-1:0]};	// everything below is sticky

	assign o_m4_shl_hi = shl[`FPU_MUL_M5_W -: 2];

	////////////////////////////////////////////////////////////////////////////
	// stage-5 fraction select
	////////////////////////////////////////////////////////////////////////////

	// top bit clear takes one more place, sticky stays at bit 0 side
	assign m5_in = ({`FPU_MUL_M5_W{i_left & shl[`FPU_MUL_M5_W]}}
			& shl[`FPU_MUL_M5_W-1:0])
		| ({`FPU_MUL_M5_W{i_left & ~shl[`FPU_MUL_M5_W]}}
			& {shl[`FPU_MUL_M5_W-2:0], 1'b0})
		| ({`FPU_MUL_M5_W{i_right & shr[`FPU_MUL_M5_W]}}
			& shr[`FPU_MUL_M5_W-1:0])
		| ({`FPU_MUL_M5_W{i_right & ~shr[`FPU_MUL_M5_W]}}
			& {shr[`FPU_MUL_M5_W-2:0], 1'b0});

	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			m5_q <= '0;
		end else if (i_step) begin
			m5_q <= m5_in;	// holds while the pipe stalls
		end
	end

	assign o_m5_frac = m5_q;

endmodule

//--- hdl/fpu_mul_frac_rnd.sv
// stage-5 inexact flags, rounding adder, output select and result register
`include "fpu_mul_defs.svh"

module fpu_mul_frac_rnd (
	input  logic                     i_rclk,
	input  logic                     i_reset,
	input  logic                     i_step,
	input  fpu_mul_fmt_pkg::m5frac_t i_m5_frac,
	input  fpu_mul_ctl_pkg::m5_sel_t i_m5_sel,
	output fpu_mul_fmt_pkg::m5flags_t o_flags,
	output fpu_mul_fmt_pkg::res_t    o_frac_out
);

	logic [`FPU_MUL_OUT_W:0] add_sum;	// carry on top
	fpu_mul_fmt_pkg::res_t   frac_hi;	// bits 54:3, unrounded
	fpu_mul_fmt_pkg::res_t   out_in;
	fpu_mul_fmt_pkg::res_t   out_q;

	assign frac_hi = i_m5_frac[`FPU_MUL_M5_W-1:3];

	// inexact chain, each wider than the last
	assign o_flags.dbl_nx = |i_m5_frac[2:0];
	assign o_flags.sng_nx = o_flags.dbl_nx | (|i_m5_frac[31:3]);
	assign o_flags.neq_0  = o_flags.sng_nx | (|i_m5_frac[`FPU_MUL_M5_W-1:32]);

	////////////////////////////////////////////////////////////////////////////
	// rounding
	////////////////////////////////////////////////////////////////////////////

	// single lsb lands at bit 29 of the 52-bit field
	assign add_sum = {1'b0, frac_hi}
		+ {23'b0, i_m5_sel.inc_sng, 28'b0, i_m5_sel.inc_dbl};

	assign o_flags.cout = add_sum[`FPU_MUL_OUT_W];

	assign out_in = ({`FPU_MUL_OUT_W{i_m5_sel.sel_add}} & add_sum[`FPU_MUL_OUT_W-1:0])
		| ({`FPU_MUL_OUT_W{i_m5_sel.sel_frac}} & frac_hi)
		| {`FPU_MUL_OUT_W{i_m5_sel.sel_max}};	// max finite fraction

	always_ff @(posedge i_rclk) begin
		if (i_reset) begin
			out_q <= '0;
		end else if (i_step) begin
			out_q <= out_in;
		end
	end

	assign o_frac_out = out_q;

endmodule

//--- hdl/fpu_mul_frac_dp.sv
// multiply fraction datapath top, control decode plus stage 1, 4 and 5 datapath
`include "fpu_mul_defs.svh"

module fpu_mul_frac_dp (
	input  logic                        i_rclk,
	input  logic                        i_reset,
	input  logic                        i_step,	// pipe advance, level
	input  fpu_mul_fmt_pkg::opnd_t      i_in1,
	input  fpu_mul_fmt_pkg::opnd_t      i_in2,
	input  fpu_mul_ctl_pkg::m1_op_t     i_m1_op,
	input  fpu_mul_fmt_pkg::prod_t      i_m4_frac,	// from the array
	input  logic [`FPU_MUL_SHCNT_W-1:0] i_m4_sh_cnt,
	input  logic [`FPU_MUL_LD0_W:0]     i_m3b_ld0_inv,
	input  logic                        i_left,
	input  logic                        i_right,
	input  fpu_mul_ctl_pkg::m5_op_t     i_m5_op,
	output fpu_mul_fmt_pkg::frac_t      o_frac1_array,	// to the array
	output fpu_mul_fmt_pkg::frac_t      o_frac2_array,
	output logic [`FPU_MUL_LD0_W-1:0]   o_ld0_1,
	output logic [`FPU_MUL_LD0_W-1:0]   o_ld0_2,
	output logic                        o_m4_frac_105,
	output logic [`FPU_MUL_LD0_W:0]     o_m3_ld0_inv,
	output logic [1:0]                  o_m4_shl_hi,
	output logic [32:0]                 o_m5_frac_lo,	// to exponent side
	output fpu_mul_fmt_pkg::m5flags_t   o_m5_flags,
	output fpu_mul_fmt_pkg::res_t       o_mul_frac_out
);

	fpu_mul_ctl_pkg::m1_sel_t m1_sel;
	fpu_mul_ctl_pkg::m5_sel_t m5_sel;
	fpu_mul_fmt_pkg::m5frac_t m5_frac;

	fpu_mul_ctl u_ctl (
		.i_rclk   (i_rclk),
		.i_reset  (i_reset),
		.i_step   (i_step),
		.i_m1_op  (i_m1_op),
		.i_m5_op  (i_m5_op),
		.o_m1_sel (m1_sel),
		.o_m5_sel (m5_sel)
	);

	// stage 1
	fpu_mul_frac_in u_frac_in (
		.i_rclk        (i_rclk),
		.i_reset       (i_reset),
		.i_step        (i_step),
		.i_in1         (i_in1),
		.i_in2         (i_in2),
		.i_m1_sel      (m1_sel),
		.o_frac1_array (o_frac1_array),
		.o_frac2_array (o_frac2_array),
		.o_ld0_1       (o_ld0_1),
		.o_ld0_2       (o_ld0_2)
	);

	assign o_m4_frac_105 = i_m4_frac[`FPU_MUL_PROD_W-1];	// product msb for exp adjust

	// stage 4
	fpu_mul_frac_norm u_frac_norm (
		.i_rclk        (i_rclk),
		.i_reset       (i_reset),
		.i_step        (i_step),
		.i_m4_frac     (i_m4_frac),
		.i_m4_sh_cnt   (i_m4_sh_cnt),
		.i_m3b_ld0_inv (i_m3b_ld0_inv),
		.i_left        (i_left),
		.i_right       (i_right),
		.o_m3_ld0_inv  (o_m3_ld0_inv),
		.o_m4_shl_hi   (o_m4_shl_hi),
		.o_m5_frac     (m5_frac)
	);

	assign o_m5_frac_lo = m5_frac[32:0];

	// stage 5
	fpu_mul_frac_rnd u_frac_rnd (
		.i_rclk     (i_rclk),
		.i_reset    (i_reset),
		.i_step     (i_step),
		.i_m5_frac  (m5_frac),
		.i_m5_sel   (m5_sel),
		.o_flags    (o_m5_flags),
		.o_frac_out (o_mul_frac_out)
	);

endmodule

//--- sim/tb_fpu_mul_frac_dp.sv
// directed testbench for the multiply fraction datapath, clock, reset, tests and compare tasks
`include "fpu_mul_defs.svh"

module tb_fpu_mul_frac_dp;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STEP_TIMEOUT = 50;	// cycles allowed per wait

	logic                          i_rclk;
	logic                          i_reset;
	logic                          i_step;
	fpu_mul_fmt_pkg::opnd_t        i_in1;
	fpu_mul_fmt_pkg::opnd_t        i_in2;
	fpu_mul_ctl_pkg::m1_op_t       i_m1_op;
	fpu_mul_fmt_pkg::prod_t        i_m4_frac;
	logic [`FPU_MUL_SHCNT_W-1:0]   i_m4_sh_cnt;
	logic [`FPU_MUL_LD0_W:0]       i_m3b_ld0_inv;
	logic                          i_left;
	logic                          i_right;
	fpu_mul_ctl_pkg::m5_op_t       i_m5_op;
	fpu_mul_fmt_pkg::frac_t        o_frac1_array;
	fpu_mul_fmt_pkg::frac_t        o_frac2_array;
	logic [`FPU_MUL_LD0_W-1:0]     o_ld0_1;
	logic [`FPU_MUL_LD0_W-1:0]     o_ld0_2;
	logic                          o_m4_frac_105;
	logic [`FPU_MUL_LD0_W:0]       o_m3_ld0_inv;
	logic [1:0]                    o_m4_shl_hi;
	logic [32:0]                   o_m5_frac_lo;
	fpu_mul_fmt_pkg::m5flags_t     o_m5_flags;
	fpu_mul_fmt_pkg::res_t         o_mul_frac_out;

	int n_checks;
	int n_errors;

	fpu_mul_frac_dp u_dut (.*);

	initial begin
		i_rclk = 1'b0;
		forever #20 i_rclk = ~i_rclk;	// 40 ns period
	end

	// step is a level, one stall cycle in five so every stage has to hold
	initial begin : step_gen
		int cyc;
		cyc    = 0;
		i_step = 1'b1;
		forever begin
			@(posedge i_rclk);
			cyc++;
			i_step <= (cyc % 5) != 3;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_frac(input string what, input fpu_mul_fmt_pkg::frac_t got,
		input fpu_mul_fmt_pkg::frac_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_res(input string what, input fpu_mul_fmt_pkg::res_t got,
		input fpu_mul_fmt_pkg::res_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flags(input string what, input fpu_mul_fmt_pkg::m5flags_t got,
		input fpu_mul_fmt_pkg::m5flags_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error at %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_cnt(input string what, input logic [`FPU_MUL_LD0_W-1:0] got,
		input logic [`FPU_MUL_LD0_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error at %0d ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// narrow side outputs, zero-extended
	task automatic check_word(input string what, input logic [32:0] got,
		input logic [32:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_counts();
		$display("checks run %0d, errors %0d", n_checks, n_errors);
	endtask

	// counts rising edges with step high, then moves to the falling edge to sample
	task automatic wait_steps(input int n);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while (seen < n && cycles < STEP_TIMEOUT) begin
			@(posedge i_rclk);
			cycles++;
			if (i_step)
				seen++;
		end
		@(negedge i_rclk);
		if (seen < n) begin
			$display("timeout: only %0d of %0d pipe steps seen in %0d cycles", seen, n, cycles);
			report_counts();
			$display("=== FAIL ===");
			$finish;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference rules
	////////////////////////////////////////////////////////////////////////////

	function automatic fpu_mul_fmt_pkg::opnd_t rand_opnd();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[`FPU_MUL_IN_W-1:0];
	endfunction

	function automatic fpu_mul_fmt_pkg::prod_t rand_prod();
		logic [127:0] r;
		r = {$urandom, $urandom, $urandom, $urandom};
		return r[`FPU_MUL_PROD_W-1:0] >> ($urandom % 4);	// a few leading zeros
	endfunction

	// hidden bit, top fraction bit quieted by snan, rest of the fraction
	function automatic fpu_mul_fmt_pkg::frac_t norm_frac(input fpu_mul_fmt_pkg::opnd_t op,
		input logic dbl, input logic snan);
		if (dbl)
			return {1'b1, op[51] | snan, op[50:0]};
		return {1'b1, op[54] | snan, op[53:32], 29'b0};	// 23 bits then zeros
	endfunction

	// denormal, fraction one place up with no hidden bit
	function automatic fpu_mul_fmt_pkg::frac_t dnrm_frac(input fpu_mul_fmt_pkg::opnd_t op,
		input logic dbl);
		if (dbl)
			return {op[51:0], 1'b0};
		return {op[54:32], 30'b0};
	endfunction

	function automatic logic [`FPU_MUL_LD0_W-1:0] count_lead0(input fpu_mul_fmt_pkg::frac_t f);
		int n;
		n = 53;	// nothing set
		for (int i = 0; i <= 52; i++)
			if (f[i])
				n = 52 - i;	// highest set bit wins
		return n;
	endfunction

	// random denormal with a random number of leading zeros in its format
	function automatic fpu_mul_fmt_pkg::opnd_t rand_dnrm(input logic dbl);
		fpu_mul_fmt_pkg::opnd_t op;
		logic [63:0]            r;
		int                     lz;
		op = rand_opnd();
		r  = {$urandom, $urandom};
		if (dbl) begin
			lz       = $urandom % 52;
			op[51:0] = (r[51:0] >> lz) | (52'd1 << (51 - lz));
		end else begin
			lz        = $urandom % 23;
			op[54:32] = (r[22:0] >> lz) | (23'd1 << (22 - lz));
		end
		return op;
	endfunction

	// 54 bits below the leading one plus sticky, one more place if the top is clear
	function automatic fpu_mul_fmt_pkg::m5frac_t m5_ref(input fpu_mul_fmt_pkg::prod_t prod,
		input logic [5:0] cnt, input logic left);
		fpu_mul_fmt_pkg::prod_t shl;
		logic [168:0]           w;	// product over 63 places of guard
		logic [55:0]            v;
		shl = prod << cnt;
		if (left)
			w = {shl, 63'b0};
		else
			w = {prod, 63'b0} >> cnt;
		v = {w[168:114], |w[113:0]};
		if (!v[55])
			v = v << 1;
		return v[54:0];
	endfunction

	function automatic fpu_mul_ctl_pkg::m1_op_t mk_m1_op(input logic dbl,
		input fpu_mul_ctl_pkg::opnd_class_t c1, input fpu_mul_ctl_pkg::opnd_class_t c2,
		input logic s1, input logic s2, input logic iz);
		fpu_mul_ctl_pkg::m1_op_t op;
		op.dblop    = dbl;
		op.class1   = c1;
		op.class2   = c2;
		op.snan1    = s1;
		op.snan2    = s2;
		op.inf_zero = iz;
		return op;
	endfunction

	function automatic fpu_mul_ctl_pkg::m5_op_t mk_m5_op(input logic sng, input logic dbl,
		input logic rnd, input logic of, input logic to0);
		fpu_mul_ctl_pkg::m5_op_t op;
		op.fmuls    = sng;
		op.fmulda   = dbl;
		op.round_up = rnd;
		op.in_of    = of;
		op.to_0     = to0;
		return op;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// drive and check
	////////////////////////////////////////////////////////////////////////////

	task automatic run_stage1(input fpu_mul_fmt_pkg::opnd_t a, input fpu_mul_fmt_pkg::opnd_t b,
		input fpu_mul_ctl_pkg::m1_op_t op, input fpu_mul_fmt_pkg::frac_t exp1,
		input fpu_mul_fmt_pkg::frac_t exp2);
		@(posedge i_rclk);
		i_in1   <= a;
		i_in2   <= b;
		i_m1_op <= op;
		wait_steps(1);
		check_frac("frac1 array", o_frac1_array, ~exp1);	// array takes op1 inverted
		check_frac("frac2 array", o_frac2_array, exp2);
		check_cnt("lead0 op1", o_ld0_1, count_lead0(dnrm_frac(a, op.dblop)));
		check_cnt("lead0 op2", o_ld0_2, count_lead0(dnrm_frac(b, op.dblop)));
	endtask

	task automatic run_stage5(input fpu_mul_fmt_pkg::prod_t prod, input logic [5:0] cnt,
		input logic left, input fpu_mul_ctl_pkg::m5_op_t op);
		fpu_mul_fmt_pkg::m5frac_t  m5;
		fpu_mul_fmt_pkg::prod_t    shl;
		fpu_mul_fmt_pkg::m5flags_t flags;
		fpu_mul_fmt_pkg::res_t     res;
		logic [52:0]               inc;
		logic [52:0]               sum;
		logic [6:0]                ld0_inv;
		m5      = m5_ref(prod, cnt, left);
		shl     = prod << cnt;
		ld0_inv = $urandom % 128;
		inc     = '0;
		if (op.fmuls)
			inc[29] = 1'b1;	// single lsb
		else if (op.fmulda)
			inc[0] = 1'b1;
		sum          = {1'b0, m5[54:3]} + inc;
		flags.dbl_nx = |m5[2:0];
		flags.sng_nx = |m5[31:0];
		flags.neq_0  = |m5;
		flags.cout   = sum[52];
		if (op.in_of)
			res = op.to_0 ? '1 : '0;	// max finite or infinity
		else if (op.round_up)
			res = sum[51:0];
		else
			res = m5[54:3];
		@(posedge i_rclk);
		i_m4_frac     <= prod;
		i_m4_sh_cnt   <= cnt;
		i_m3b_ld0_inv <= ld0_inv;
		i_left        <= left;
		i_right       <= ~left;
		i_m5_op       <= op;
		wait_steps(3);	// count reg, stage-5 fraction, result
		check_word("m5 frac lo", o_m5_frac_lo, m5[32:0]);
		check_flags("m5 flags", o_m5_flags, flags);
		check_res("result fraction", o_mul_frac_out, res);
		check_word("left shift hi", {31'b0, o_m4_shl_hi}, {31'b0, shl[105:104]});
		check_word("ld0 sum", {26'b0, o_m3_ld0_inv}, {26'b0, ld0_inv});
		check_word("product msb", {32'b0, o_m4_frac_105}, {32'b0, prod[105]});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		@(negedge i_rclk);
		check_res("result after reset", o_mul_frac_out, '0);
		check_flags("flags after reset", o_m5_flags, '0);
		check_word("ld0 sum after reset", {26'b0, o_m3_ld0_inv}, '0);
	endtask

	task automatic test_normal();
		fpu_mul_fmt_pkg::opnd_t a;
		fpu_mul_fmt_pkg::opnd_t b;
		logic                   dbl;
		logic                   snan;
		for (int i = 0; i < 8; i++) begin
			dbl  = i[1];
			snan = i[0];	// op2 gets the other flag value
			a    = rand_opnd();
			b    = rand_opnd();
			run_stage1(a, b, mk_m1_op(dbl, fpu_mul_ctl_pkg::CLS_NORM, fpu_mul_ctl_pkg::CLS_NORM,
				snan, ~snan, 1'b0), norm_frac(a, dbl, snan), norm_frac(b, dbl, ~snan));
		end
	endtask

	task automatic test_denormal();
		fpu_mul_fmt_pkg::opnd_t a;
		fpu_mul_fmt_pkg::opnd_t b;
		logic                   dbl;
		for (int i = 0; i < 10; i++) begin
			dbl = i[0];
			a   = rand_dnrm(dbl);
			b   = rand_dnrm(dbl);
			run_stage1(a, b, mk_m1_op(dbl, fpu_mul_ctl_pkg::CLS_DNRM, fpu_mul_ctl_pkg::CLS_DNRM,
				1'b0, 1'b0, 1'b0), dnrm_frac(a, dbl), dnrm_frac(b, dbl));
		end
		// zero op1 injects nothing, count runs to 53
		b = rand_dnrm(1'b1);
		run_stage1('0, b, mk_m1_op(1'b1, fpu_mul_ctl_pkg::CLS_ZERO, fpu_mul_ctl_pkg::CLS_DNRM,
			1'b0, 1'b0, 1'b0), '0, dnrm_frac(b, 1'b1));
	endtask

	task automatic test_infinity();
		logic dbl;
		logic iz;
		for (int i = 0; i < 4; i++) begin
			dbl = i[1];
			iz  = i[0];
			run_stage1(rand_opnd(), rand_opnd(), mk_m1_op(dbl, fpu_mul_ctl_pkg::CLS_INF,
				fpu_mul_ctl_pkg::CLS_INF, 1'b0, 1'b0, iz), {1'b1, 52'b0},
				{1'b1, {23{iz}}, {29{iz & dbl}}});
		end
	endtask

	task automatic test_shift();
		for (int i = 0; i < 12; i++)
			run_stage5(rand_prod(), $urandom % 64, i[0],
				mk_m5_op(i[1], ~i[1], 1'b0, 1'b0, 1'b0));	// unrounded
	endtask

	task automatic test_round();
		fpu_mul_fmt_pkg::prod_t ones;
		ones = '1;	// all-ones fraction, carries all the way out
		run_stage5(ones, 6'd0, 1'b1, mk_m5_op(1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
		run_stage5(ones, 6'd0, 1'b1, mk_m5_op(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
		run_stage5(ones, 6'd0, 1'b1, mk_m5_op(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		run_stage5(ones, 6'd0, 1'b1, mk_m5_op(1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
		run_stage5(ones, 6'd0, 1'b1, mk_m5_op(1'b0, 1'b1, 1'b1, 1'b1, 1'b0));	// to infinity
		for (int i = 0; i < 8; i++)
			run_stage5(rand_prod(), $urandom % 8, $urandom % 2,
				mk_m5_op(i[0], ~i[0], 1'b1, i == 7, 1'b1));	// last one overflows
	endtask

	initial begin : main
		int seed;
		seed = 32'hd1c378cd;
		void'($urandom(seed));
		n_checks      = 0;
		n_errors      = 0;
		i_reset       = 1'b1;
		i_in1         = '0;
		i_in2         = '0;
		i_m1_op       = '0;
		i_m4_frac     = '0;
		i_m4_sh_cnt   = '0;
		i_m3b_ld0_inv = '0;
		i_left        = 1'b0;
		i_right       = 1'b0;
		i_m5_op       = '0;
		repeat (10) @(posedge i_rclk);
		i_reset <= 1'b0;
		test_reset();
		test_normal();
		test_denormal();
		test_infinity();
		test_shift();
		test_round();
		report_counts();
		if (n_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
hdl/fpu_mul_fmt_pkg.sv
hdl/fpu_mul_ctl_pkg.sv
hdl/fpu_mul_lead0.sv
hdl/fpu_mul_ctl.sv
hdl/fpu_mul_frac_in.sv
hdl/fpu_mul_frac_norm.sv
hdl/fpu_mul_frac_rnd.sv
hdl/fpu_mul_frac_dp.sv
sim/tb_fpu_mul_frac_dp.sv

//--- Bender.yml
package:
  name: fpu_mul_frac_dp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/fpu_mul_fmt_pkg.sv
      - hdl/fpu_mul_ctl_pkg.sv
      - hdl/fpu_mul_lead0.sv
      - hdl/fpu_mul_ctl.sv
      - hdl/fpu_mul_frac_in.sv
      - hdl/fpu_mul_frac_norm.sv
      - hdl/fpu_mul_frac_rnd.sv
      - hdl/fpu_mul_frac_dp.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_fpu_mul_frac_dp.sv
